//--- build.f
+incdir+.
ic_addr_pkg.sv
ic_bus_pkg.sv
ic_refill_fsm.sv
ic_beat_counter.sv
ic_tag_store.sv
ic_line_store.sv
icache_top.sv
icache_properties.sv
tb_icache.sv

//--- Makefile
TOP = tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- tb_icache.sv
/* instruction cache testbench */

`timescale 1ns/10ps

module tb_icache;

  import ic_bus_pkg::*;

  typedef struct packed {
    logic [31:0] addr;
    logic        flush;
    logic        refill;
  } stim_t;

  localparam int NUM_STIM   = 14;
  // 40 cycles per fetch plus the reset cycles
  localparam int MAX_CYCLES = NUM_STIM * 40 + 8;

  logic          clk;
  logic          rst_n;
  logic          flush;
  logic          ready;
  ic_fetch_req_t fetch_req;
  ic_fetch_rsp_t fetch_rsp;
  ic_mem_req_t   mem_req;
  ic_mem_rsp_t   mem_rsp;
  stim_t         stim_tab [NUM_STIM];
  string         stim_name [NUM_STIM];
  string         test_name;
  int            stim_cnt;
  int            cycles;
  int            mem_reqs;
  int            seed;
  logic [31:0]   last_line;

  icache_top i_icache_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .fetch_req_i (fetch_req),
    .ready_o     (ready),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no response within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  // ==========================================================
  // memory model
  // ==========================================================

  // word at byte address a is a ^ 32'hc0de0000
  always @(negedge clk) begin
    if (rst_n && mem_req.rd) begin
      mem_reqs = mem_reqs + 1;
      last_line = mem_req.addr;
      // first beat no earlier than the REFILL state
      @(negedge clk);
      for (int b = 0; b < 4; b++) begin
        repeat ($random(seed) & 3) @(negedge clk);
        mem_rsp = '{valid: 1'b1, data: (last_line + 4 * b) ^ 32'hc0de0000};
        @(negedge clk);
        mem_rsp = '0;
      end
    end
  end

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic add_stim(input string name, input logic [31:0] addr, input logic fl,
                          input logic rf);
    stim_name[stim_cnt] = name;
    stim_tab[stim_cnt] = '{addr: addr, flush: fl, refill: rf};
    stim_cnt++;
  endtask

  // one request from IDLE, wait for the response, back to IDLE
  task automatic run_fetch(input stim_t s);
    int lat;
    int reqs_before;
    reqs_before = mem_reqs;
    if (s.flush) begin
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
    end
    check("ready before request", 32'h1, 32'(ready));
    fetch_req.valid = 1'b1;
    fetch_req.addr = s.addr;
    @(negedge clk);
    fetch_req.valid = 1'b0;
    lat = 1;
    while (!fetch_rsp.valid) begin
      check("ready while waiting", 32'h0, 32'(ready));
      @(negedge clk);
      lat++;
    end
    check("instruction", s.addr ^ 32'hc0de0000, fetch_rsp.instr);
    check("memory requests", 32'(s.refill), mem_reqs - reqs_before);
    if (s.refill) begin
      check("line address", {s.addr[31:4], 4'h0}, last_line);
    end else begin
      check("hit latency", 32'd1, lat);
    end
    @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    fetch_req = '0;
    mem_rsp = '0;
    cycles = 0;
    mem_reqs = 0;
    stim_cnt = 0;
    seed = 32'h67eb;
    last_line = '0;
    // set 0 holds tags A 0x1000, B 0x1080, C 0x1100
    add_stim("cold_miss", 32'h0000_1000, 1'b0, 1'b1);
    add_stim("same_line", 32'h0000_1008, 1'b0, 1'b0);
    add_stim("second_tag", 32'h0000_1080, 1'b0, 1'b1);
    add_stim("touch_a", 32'h0000_1004, 1'b0, 1'b0);
    add_stim("third_tag", 32'h0000_1100, 1'b0, 1'b1);
    add_stim("kept_line", 32'h0000_1000, 1'b0, 1'b0);
    add_stim("evicted_line", 32'h0000_1084, 1'b0, 1'b1);
    add_stim("other_set", 32'h0000_2030, 1'b0, 1'b1);
    add_stim("other_set_hit", 32'h0000_2034, 1'b0, 1'b0);
    add_stim("flush_refill", 32'h0000_1008, 1'b1, 1'b1);
    add_stim("flush_other", 32'h0000_2038, 1'b0, 1'b1);
    add_stim("after_flush_hit", 32'h0000_100c, 1'b0, 1'b0);
    add_stim("last_set", 32'h0000_3ffc, 1'b0, 1'b1);
    add_stim("last_set_hit", 32'h0000_3ff0, 1'b0, 1'b0);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    test_name = "reset";
    check("ready", 32'h1, 32'(ready));
    check("response valid", 32'h0, 32'(fetch_rsp.valid));
    check("memory read", 32'h0, 32'(mem_req.rd));
    for (int i = 0; i < NUM_STIM; i++) begin
      test_name = stim_name[i];
      run_fetch(stim_tab[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- icache_properties.sv
/* refill protocol assertions */

`timescale 1ns/10ps

module icache_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  ready_i,
  input ic_bus_pkg::ic_mem_req_t mem_req_i,
  input ic_bus_pkg::ic_state_e   state_i
);

  import ic_bus_pkg::*;

  // read strobe is a single-cycle pulse
  rd_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_i.rd |=> !mem_req_i.rd)
    else $error("memory read strobe high for two cycles");

  // no new request taken while a line is coming in
  no_ready_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == REFILL) |-> !ready_i)
    else $error("ready high during refill");

endmodule

bind icache_top icache_properties i_icache_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .ready_i   (ready_o),
  .mem_req_i (mem_req_o),
  .state_i   (state)
);

//--- icache_top.sv
/* two-way instruction cache */

`timescale 1ns/10ps

`include "ic_macros.svh"

module icache_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  ic_bus_pkg::ic_fetch_req_t fetch_req_i,
  output logic                      ready_o,
  output ic_bus_pkg::ic_fetch_rsp_t fetch_rsp_o,
  output ic_bus_pkg::ic_mem_req_t   mem_req_o,
  input  ic_bus_pkg::ic_mem_rsp_t   mem_rsp_i
);

  import ic_addr_pkg::*;
  import ic_bus_pkg::*;

  ic_state_e                 state;
  ic_addr_u                  req_q;
  logic                      accept;
  logic                      lookup;
  logic                      refill;
  logic                      flush_en;
  logic                      hit;
  logic                      hit_way;
  logic                      fill_way;
  logic                      line_way;
  logic                      last_beat;
  logic                      rsp_valid;
  logic                      mem_rd;
  logic [`IC_WORDS_LOG2-1:0] beat_idx;
  logic [31:0]               word;

  // ==========================================================
  // request stage
  // ==========================================================

  assign accept = fetch_req_i.valid && ready_o;

  // held for the lookup and any replay after a refill
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= fetch_req_i.addr;
    end
  end

  assign lookup   = (state == LOOKUP);
  assign refill   = (state == REFILL);
  assign flush_en = flush_i && (state == IDLE);
  // victim while filling, hitting way otherwise
  assign line_way = refill ? fill_way : hit_way;

  always_comb begin
    mem_req_o.rd      = mem_rd;
    mem_req_o.addr    = {req_q.word[`IC_ADDR_W-1:`IC_LINE_OFS], {`IC_LINE_OFS{1'b0}}};
    fetch_rsp_o.valid = rsp_valid;
    fetch_rsp_o.instr = word;
  end

  // ==========================================================
  // blocks
  // ==========================================================

  ic_refill_fsm i_ic_refill_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .accept_i    (accept),
    .hit_i       (hit),
    .last_beat_i (last_beat),
    .state_o     (state),
    .ready_o     (ready_o),
    .rsp_valid_o (rsp_valid),
    .mem_rd_o    (mem_rd)
  );

  ic_beat_counter i_ic_beat_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .refill_i    (refill),
    .beat_i      (mem_rsp_i.valid),
    .beat_idx_o  (beat_idx),
    .last_beat_o (last_beat)
  );

  ic_tag_store i_ic_tag_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_en),
    .addr_i     (req_q),
    .lookup_i   (lookup),
    .fill_i     (last_beat),
    .hit_o      (hit),
    .hit_way_o  (hit_way),
    .fill_way_o (fill_way)
  );

  ic_line_store i_ic_line_store (
    .clk         (clk),
    .addr_i      (req_q),
    .way_i       (line_way),
    .beat_we_i   (refill && mem_rsp_i.valid),
    .beat_idx_i  (beat_idx),
    .beat_data_i (mem_rsp_i.data),
    .word_o      (word)
  );

endmodule

//--- ic_line_store.sv
/* instruction line storage */

`timescale 1ns/10ps

`include "ic_macros.svh"

module ic_line_store (
  input  logic                      clk,
  input  ic_addr_pkg::ic_addr_u     addr_i,
  input  logic                      way_i,
  input  logic                      beat_we_i,
  input  logic [`IC_WORDS_LOG2-1:0] beat_idx_i,
  input  logic [31:0]               beat_data_i,
  output logic [31:0]               word_o
);

  // way, set, word
  logic [31:0] word_q [2][`IC_SETS][`IC_WORDS];

  // one refill word per beat, into the victim way
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      word_q[way_i][addr_i.f.index][beat_idx_i] <= beat_data_i;
    end
  end

  // word picked by the held offset in the hitting way
  assign word_o = word_q[way_i][addr_i.f.index][addr_i.f.offset];

endmodule

//--- ic_tag_store.sv
/* tag, valid and LRU state */

`timescale 1ns/10ps

`include "ic_macros.svh"

module ic_tag_store (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  ic_addr_pkg::ic_addr_u addr_i,
  input  logic                  lookup_i,
  input  logic                  fill_i,
  output logic                  hit_o,
  output logic                  hit_way_o,
  output logic                  fill_way_o
);

  logic [`IC_TAG_W-1:0]     tag_q [2][`IC_SETS];
  logic [`IC_SETS-1:0][1:0] valid_q;
  // per set, the way to evict next
  logic [`IC_SETS-1:0]      lru_q;
  logic [1:0]               set_valid;
  logic [1:0]               way_hit;

  // ==========================================================
  // compare
  // ==========================================================

  assign set_valid = valid_q[addr_i.f.index];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = set_valid[w] && (tag_q[w][addr_i.f.index] == addr_i.f.tag);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];

  // empty way first, otherwise the least recently used one
  always_comb begin
    if (!set_valid[0]) begin
      fill_way_o = 1'b0;
    end else if (!set_valid[1]) begin
      fill_way_o = 1'b1;
    end else begin
      fill_way_o = lru_q[addr_i.f.index];
    end
  end

  // ==========================================================
  // update
  // ==========================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      lru_q   <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[addr_i.f.index][fill_way_o] <= 1'b1;
      lru_q[addr_i.f.index]               <= ~fill_way_o;
    end else if (lookup_i && hit_o) begin
      lru_q[addr_i.f.index] <= ~hit_way_o;
    end
  end

  // tag lands together with the last word of the line
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tag_q[fill_way_o][addr_i.f.index] <= addr_i.f.tag;
    end
  end

endmodule

//--- ic_beat_counter.sv
/* refill beat counter */

`timescale 1ns/10ps

`include "ic_macros.svh"

module ic_beat_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      refill_i,
  input  logic                      beat_i,
  output logic [`IC_WORDS_LOG2-1:0] beat_idx_o,
  output logic                      last_beat_o
);

  logic [`IC_WORDS_LOG2-1:0] cnt_q;
  logic [`IC_WORDS_LOG2-1:0] cnt_inc;

  assign cnt_inc = cnt_q + {{(`IC_WORDS_LOG2-1){1'b0}}, 1'b1};

  // word position within the line, back to zero between refills
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!refill_i) begin
      cnt_q <= '0;
    end else if (beat_i) begin
      cnt_q <= cnt_inc;
    end
  end

  assign beat_idx_o = cnt_q;

  // fourth word arriving now
  assign last_beat_o = refill_i && beat_i && (cnt_q == '1);

endmodule

//--- ic_refill_fsm.sv
/* lookup and refill FSM */

`timescale 1ns/10ps

module ic_refill_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  accept_i,
  input  logic                  hit_i,
  input  logic                  last_beat_i,
  output ic_bus_pkg::ic_state_e state_o,
  output logic                  ready_o,
  output logic                  rsp_valid_o,
  output logic                  mem_rd_o
);

  import ic_bus_pkg::*;

  ic_state_e state_q;
  ic_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        // a hit may take the next request back to back
        if (!hit_i) begin
          state_d = MISS;
        end else if (!accept_i) begin
          state_d = IDLE;
        end
      end
      // read strobe lasts this one cycle only
      MISS: begin
        state_d = REFILL;
      end
      REFILL: begin
        // replay the held lookup once the line is in
        if (last_beat_i) begin
          state_d = LOOKUP;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o     = state_q;
  assign ready_o     = (state_q == IDLE) || ((state_q == LOOKUP) && hit_i);
  assign rsp_valid_o = (state_q == LOOKUP) && hit_i;
  assign mem_rd_o    = (state_q == MISS);

endmodule

//--- ic_bus_pkg.sv
/* fetch and memory port types */

`include "ic_macros.svh"

package ic_bus_pkg;

  // fetch side request, word aligned
  typedef struct packed {
    logic                  valid;
    ic_addr_pkg::ic_addr_u addr;
  } ic_fetch_req_t;

  // one instruction back
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } ic_fetch_rsp_t;

  // single-cycle read strobe, address is line aligned
  typedef struct packed {
    logic                  rd;
    logic [`IC_ADDR_W-1:0] addr;
  } ic_mem_req_t;

  // one pulse per returned word
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } ic_mem_rsp_t;

  // refill sequencing
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    MISS,
    REFILL
  } ic_state_e;

endpackage

//--- ic_addr_pkg.sv
/* fetch address layout */

`include "ic_macros.svh"

package ic_addr_pkg;

  // ==========================================================
  // field view
  // ==========================================================

  // tag, set index, word in line, byte in word
  typedef struct packed {
    logic [`IC_TAG_W-1:0]      tag;
    logic [`IC_SETS_LOG2-1:0]  index;
    logic [`IC_WORDS_LOG2-1:0] offset;
    logic [`IC_BYTE_BITS-1:0]  byte_sel;
  } ic_addr_fields_t;

  // ==========================================================
  // two readings of one address
  // ==========================================================

  // flat word for the memory side, fields for the lookup
  typedef union packed {
    logic [`IC_ADDR_W-1:0] word;
    ic_addr_fields_t       f;
  } ic_addr_u;

endpackage

//--- ic_macros.svh
/* instruction cache geometry */

`ifndef IC_MACROS_SVH
`define IC_MACROS_SVH

// fetch address width in bits
`define IC_ADDR_W 32

// 8 sets
`define IC_SETS_LOG2 3
`define IC_SETS (1 << `IC_SETS_LOG2)

// 4 words per line
`define IC_WORDS_LOG2 2
`define IC_WORDS (1 << `IC_WORDS_LOG2)

// byte select below the word offset
`define IC_BYTE_BITS 2

// everything above index and word offset
`define IC_TAG_W (`IC_ADDR_W - `IC_SETS_LOG2 - `IC_WORDS_LOG2 - `IC_BYTE_BITS)

// low address bits spanned by one line
`define IC_LINE_OFS (`IC_WORDS_LOG2 + `IC_BYTE_BITS)

`endif
